// File: cpu_core_top.f
+incdir+logic
logic/cpu_pkg.sv
logic/mem_bus_if.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/bus_arbiter.sv
logic/reg_file.sv
logic/alu.sv
logic/core_sequencer.sv
logic/cpu_core_top.sv
tb/tb_memory.sv
tb/cpu_core_tb.sv

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
	input  opcode_t op_i,
	input  word_t   a_i,
	input  word_t   b_i,
	output word_t   res_o,
	output logic    take_o
);

	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (op_i)
		// loads and stores use the sum as address
		OP_ADD, OP_ADDI, OP_LOAD, OP_STORE:
			res_o = a_i + b_i;
		OP_AND:
			res_o = a_i & b_i;
		OP_OR:
			res_o = a_i | b_i;
		OP_EOR:
			res_o = a_i ^ b_i;
		OP_CMP:
			res_o = word_t'($signed(a_i) < $signed(b_i));
		OP_SHL:
			res_o = a_i << shamt;
		OP_SHR:
			res_o = a_i >> shamt;
		OP_ASR:
			res_o = word_t'($signed(a_i) >>> shamt);
		default:
			res_o = '0;
		endcase
	end

	// b carries rt for branches
	always_comb begin
		case (op_i)
		OP_BEQ:  take_o = (a_i == b_i);
		OP_BNE:  take_o = (a_i != b_i);
		default: take_o = 1'b0;
		endcase
	end

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import cpu_pkg::*; (
	input  logic  clk_g,
	input  logic  rst_i,
	mem_bus_if.arbiter fetch_bus,
	mem_bus_if.arbiter data_bus,
	output logic  mem_req_valid_o,
	input  logic  mem_req_ready_i,
	output logic  mem_req_we_o,
	output addr_t mem_req_addr_o,
	output word_t mem_req_wdata_o,
	input  logic  mem_rsp_valid_i,
	input  word_t mem_rsp_rdata_i
);

	logic busy;
	logic owner_data;
	logic pick_data;

	// data side has priority
	assign pick_data = data_bus.req_valid;

	always_comb begin
		mem_req_valid_o = !busy && (fetch_bus.req_valid || data_bus.req_valid);
		if (pick_data) begin
			mem_req_we_o = data_bus.req_we;
			mem_req_addr_o = data_bus.req_addr;
			mem_req_wdata_o = data_bus.req_wdata;
		end else begin
			mem_req_we_o = fetch_bus.req_we;
			mem_req_addr_o = fetch_bus.req_addr;
			mem_req_wdata_o = fetch_bus.req_wdata;
		end
	end

	// no grant while a response is outstanding
	assign data_bus.req_ready = !busy && mem_req_ready_i && pick_data;
	assign fetch_bus.req_ready = !busy && mem_req_ready_i && !pick_data;

	assign data_bus.rsp_valid = mem_rsp_valid_i && busy && owner_data;
	assign fetch_bus.rsp_valid = mem_rsp_valid_i && busy && !owner_data;
	assign data_bus.rsp_rdata = mem_rsp_rdata_i;
	assign fetch_bus.rsp_rdata = mem_rsp_rdata_i;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			busy <= 1'b0;
			owner_data <= 1'b0;
		end else if (mem_req_valid_o && mem_req_ready_i) begin
			busy <= 1'b1;
			owner_data <= pick_data;
		end else if (mem_rsp_valid_i) begin
			busy <= 1'b0;
		end
	end

	// relies on requesters holding fields and on the sequencer's ordering
	a_req_stable: assert property (@(posedge clk_g) disable iff (rst_i)
		mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
		&& $stable(mem_req_we_o) && $stable(mem_req_addr_o) && $stable(mem_req_wdata_o));

	a_rsp_outstanding: assert property (@(posedge clk_g) disable iff (rst_i)
		mem_rsp_valid_i |-> busy);

endmodule

// File: logic/core_sequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module core_sequencer import cpu_pkg::*; (
	input  logic     clk_g,
	input  logic     rst_i,
	output logic     fetch_go_o,
	output addr_t    fetch_pc_o,
	input  logic     insn_valid_i,
	input  insn_t    insn_i,
	output logic     ls_go_o,
	output logic     ls_we_o,
	output addr_t    ls_addr_o,
	output word_t    ls_wdata_o,
	input  logic     ls_done_i,
	input  word_t    ls_rdata_i,
	output reg_idx_t rf_ra_o,
	output reg_idx_t rf_rb_o,
	input  word_t    rf_a_i,
	input  word_t    rf_b_i,
	output logic     rf_we_o,
	output reg_idx_t rf_wa_o,
	output word_t    rf_wd_o,
	output opcode_t  alu_op_o,
	output word_t    alu_a_o,
	output word_t    alu_b_o,
	input  word_t    alu_res_i,
	input  logic     alu_take_i,
	output logic     halted_o
);

	seq_state_t state;
	addr_t      pc;
	addr_t      pc_inc;
	addr_t      br_target;
	insn_t      ir;
	opcode_t    op_d;
	opcode_t    op_q;
	reg_idx_t   rt_q;
	word_t      simm;
	word_t      a_q;
	word_t      b_q;
	word_t      sd_q;
	word_t      res_q;
	logic       fetch_pend;
	logic       wb_q;

	assign op_d = opcode_t'(ir[31:28]);
	assign simm = {{(`CPU_XLEN - `CPU_IMM_W){ir[`CPU_IMM_W-1]}}, ir[`CPU_IMM_W-1:0]};
	assign pc_inc = pc + addr_t'(4);
	// word offset relative to the next instruction
	assign br_target = pc_inc + {simm[`CPU_XLEN-3:0], 2'b00};

	// stores and branches read rt on the second port
	assign rf_ra_o = ir[23:20];
	assign rf_rb_o = (op_d inside {OP_STORE, OP_BEQ, OP_BNE}) ? ir[27:24] : ir[19:16];

	assign fetch_pc_o = pc;
	assign ls_we_o = (op_q == OP_STORE);
	assign ls_addr_o = res_q;
	assign ls_wdata_o = sd_q;
	assign rf_we_o = (state == S_WRITEBACK) && wb_q;
	assign rf_wa_o = rt_q;
	assign rf_wd_o = res_q;
	assign alu_op_o = op_q;
	assign alu_a_o = a_q;
	assign alu_b_o = b_q;
	assign halted_o = (state == S_HALTED);

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state <= S_FETCH;
			pc <= `CPU_RESET_PC;
			fetch_pend <= 1'b0;
			fetch_go_o <= 1'b0;
			ls_go_o <= 1'b0;
			wb_q <= 1'b0;
		end else begin
			fetch_go_o <= 1'b0;
			ls_go_o <= 1'b0;
			case (state)
			S_FETCH: begin
				if (!fetch_pend) begin
					fetch_go_o <= 1'b1;
					fetch_pend <= 1'b1;
				end else if (insn_valid_i) begin
					fetch_pend <= 1'b0;
					state <= S_DECODE;
				end
			end
			S_DECODE:
				state <= S_EXECUTE;
			S_EXECUTE: begin
				pc <= pc_inc;
				wb_q <= 1'b0;
				state <= S_WRITEBACK;
				case (op_q)
				OP_ADD, OP_AND, OP_OR, OP_EOR, OP_CMP, OP_SHL, OP_SHR, OP_ASR, OP_ADDI:
					wb_q <= 1'b1;
				OP_LOAD, OP_STORE: begin
					ls_go_o <= 1'b1;
					state <= S_MEMORY;
				end
				OP_BEQ, OP_BNE:
					if (alu_take_i)
						pc <= br_target;
				OP_HALT:
					state <= S_HALTED;
				default: ;
				endcase
			end
			S_MEMORY:
				if (ls_done_i) begin
					wb_q <= !ls_we_o;
					state <= S_WRITEBACK;
				end
			S_WRITEBACK:
				state <= S_FETCH;
			default: ;
			endcase
		end
	end

	// instruction and operand registers
	always_ff @(posedge clk_g) begin
		case (state)
		S_FETCH:
			if (insn_valid_i)
				ir <= insn_i;
		S_DECODE: begin
			op_q <= op_d;
			rt_q <= ir[27:24];
			a_q <= rf_a_i;
			b_q <= (op_d inside {OP_ADDI, OP_LOAD, OP_STORE}) ? simm : rf_b_i;
			sd_q <= rf_b_i;
		end
		S_EXECUTE:
			res_q <= alu_res_i;
		S_MEMORY:
			if (ls_done_i && !ls_we_o)
				res_q <= ls_rdata_i;
		default: ;
		endcase
	end

	a_state_legal: assert property (@(posedge clk_g) disable iff (rst_i)
		state inside {S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY, S_WRITEBACK, S_HALTED});

	a_go_in_fetch: assert property (@(posedge clk_g) disable iff (rst_i)
		fetch_go_o |-> state == S_FETCH);

endmodule

// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path and byte address width
`define CPU_XLEN 32

// architectural registers, r0 reads zero
`define CPU_NREGS 16

// first instruction fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// signed immediate field, bits 15:0
`define CPU_IMM_W 16

`endif

// File: logic/cpu_core_top.sv
`timescale 1ns/1ps

module cpu_core_top import cpu_pkg::*; (
	input  logic  clk_g,
	input  logic  rst_i,
	output logic  mem_req_valid_o,
	input  logic  mem_req_ready_i,
	output logic  mem_req_we_o,
	output addr_t mem_req_addr_o,
	output word_t mem_req_wdata_o,
	input  logic  mem_rsp_valid_i,
	input  word_t mem_rsp_rdata_i,
	output logic  halted_o
);

	logic     fetch_go;
	addr_t    fetch_pc;
	logic     insn_valid;
	insn_t    insn;
	logic     ls_go;
	logic     ls_we;
	addr_t    ls_addr;
	word_t    ls_wdata;
	logic     ls_done;
	word_t    ls_rdata;
	reg_idx_t rf_ra;
	reg_idx_t rf_rb;
	word_t    rf_a;
	word_t    rf_b;
	logic     rf_we;
	reg_idx_t rf_wa;
	word_t    rf_wd;
	opcode_t  alu_op;
	word_t    alu_a;
	word_t    alu_b;
	word_t    alu_res;
	logic     alu_take;

	mem_bus_if fetch_bus ();
	mem_bus_if data_bus ();

	core_sequencer u_seq (
		.clk_g, .rst_i,
		.fetch_go_o(fetch_go), .fetch_pc_o(fetch_pc),
		.insn_valid_i(insn_valid), .insn_i(insn),
		.ls_go_o(ls_go), .ls_we_o(ls_we), .ls_addr_o(ls_addr), .ls_wdata_o(ls_wdata),
		.ls_done_i(ls_done), .ls_rdata_i(ls_rdata),
		.rf_ra_o(rf_ra), .rf_rb_o(rf_rb), .rf_a_i(rf_a), .rf_b_i(rf_b),
		.rf_we_o(rf_we), .rf_wa_o(rf_wa), .rf_wd_o(rf_wd),
		.alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b),
		.alu_res_i(alu_res), .alu_take_i(alu_take),
		.halted_o
	);

	fetch_unit u_fetch (
		.clk_g, .rst_i,
		.fetch_go_i(fetch_go), .fetch_pc_i(fetch_pc),
		.insn_valid_o(insn_valid), .insn_o(insn),
		.bus(fetch_bus.requester)
	);

	load_store_unit u_lsu (
		.clk_g, .rst_i,
		.ls_go_i(ls_go), .ls_we_i(ls_we), .ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata),
		.ls_done_o(ls_done), .ls_rdata_o(ls_rdata),
		.bus(data_bus.requester)
	);

	bus_arbiter u_arb (
		.clk_g, .rst_i,
		.fetch_bus(fetch_bus.arbiter), .data_bus(data_bus.arbiter),
		.mem_req_valid_o, .mem_req_ready_i, .mem_req_we_o,
		.mem_req_addr_o, .mem_req_wdata_o,
		.mem_rsp_valid_i, .mem_rsp_rdata_i
	);

	reg_file u_rf (
		.clk_g, .rst_i,
		.ra_i(rf_ra), .rb_i(rf_rb), .a_o(rf_a), .b_o(rf_b),
		.we_i(rf_we), .wa_i(rf_wa), .wd_i(rf_wd)
	);

	alu u_alu (
		.op_i(alu_op), .a_i(alu_a), .b_i(alu_b),
		.res_o(alu_res), .take_o(alu_take)
	);

endmodule

// File: logic/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [`CPU_XLEN-1:0] addr_t;
	typedef logic [31:0] insn_t;
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

	// opcode field, bits 31:28; 13 and 14 unused
	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_AND   = 4'h1,
		OP_OR    = 4'h2,
		OP_EOR   = 4'h3,
		OP_CMP   = 4'h4,
		OP_SHL   = 4'h5,
		OP_SHR   = 4'h6,
		OP_ASR   = 4'h7,
		OP_ADDI  = 4'h8,
		OP_LOAD  = 4'h9,
		OP_STORE = 4'ha,
		OP_BEQ   = 4'hb,
		OP_BNE   = 4'hc,
		OP_HALT  = 4'hf
	} opcode_t;

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXECUTE,
		S_MEMORY,
		S_WRITEBACK,
		S_HALTED
	} seq_state_t;

endpackage

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; (
	input  logic  clk_g,
	input  logic  rst_i,
	input  logic  fetch_go_i,
	input  addr_t fetch_pc_i,
	output logic  insn_valid_o,
	output insn_t insn_o,
	mem_bus_if.requester bus
);

	logic  pending;
	addr_t addr_q;

	// instruction side never writes
	assign bus.req_we = 1'b0;
	assign bus.req_wdata = '0;
	assign bus.req_addr = addr_q;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			pending <= 1'b0;
			bus.req_valid <= 1'b0;
			insn_valid_o <= 1'b0;
		end else begin
			insn_valid_o <= 1'b0;
			if (fetch_go_i) begin
				pending <= 1'b1;
				bus.req_valid <= 1'b1;
			end else if (bus.req_valid && bus.req_ready) begin
				bus.req_valid <= 1'b0;
			end else if (pending && !bus.req_valid && bus.rsp_valid) begin
				pending <= 1'b0;
				insn_valid_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_g) begin
		if (fetch_go_i)
			addr_q <= fetch_pc_i;
		if (pending && !bus.req_valid && bus.rsp_valid)
			insn_o <= bus.rsp_rdata;
	end

	// sequencer waits for insn_valid before the next go
	a_no_refetch: assert property (@(posedge clk_g) disable iff (rst_i)
		fetch_go_i |-> !pending);

endmodule

// File: logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import cpu_pkg::*; (
	input  logic  clk_g,
	input  logic  rst_i,
	input  logic  ls_go_i,
	input  logic  ls_we_i,
	input  addr_t ls_addr_i,
	input  word_t ls_wdata_i,
	output logic  ls_done_o,
	output word_t ls_rdata_o,
	mem_bus_if.requester bus
);

	logic pending;
	logic rsp_hit;

	assign rsp_hit = pending && !bus.req_valid && bus.rsp_valid;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			pending <= 1'b0;
			bus.req_valid <= 1'b0;
			ls_done_o <= 1'b0;
		end else begin
			ls_done_o <= 1'b0;
			if (ls_go_i) begin
				pending <= 1'b1;
				bus.req_valid <= 1'b1;
			end else if (bus.req_valid && bus.req_ready) begin
				bus.req_valid <= 1'b0;
			end else if (rsp_hit) begin
				// writes are acknowledged with a pulse too
				pending <= 1'b0;
				ls_done_o <= 1'b1;
			end
		end
	end

	// access held stable until accepted
	always_ff @(posedge clk_g) begin
		if (ls_go_i) begin
			bus.req_we <= ls_we_i;
			bus.req_addr <= ls_addr_i;
			bus.req_wdata <= ls_wdata_i;
		end
		if (rsp_hit && !bus.req_we)
			ls_rdata_o <= bus.rsp_rdata;
	end

	a_word_aligned: assert property (@(posedge clk_g) disable iff (rst_i)
		ls_go_i |-> ls_addr_i[1:0] == 2'b00);

endmodule

// File: logic/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if import cpu_pkg::*; ();

	// request channel
	logic  req_valid;
	logic  req_ready;
	logic  req_we;
	addr_t req_addr;
	word_t req_wdata;

	// response, single cycle pulse
	logic  rsp_valid;
	word_t rsp_rdata;

	modport requester (
		output req_valid, req_we, req_addr, req_wdata,
		input  req_ready, rsp_valid, rsp_rdata
	);

	modport arbiter (
		input  req_valid, req_we, req_addr, req_wdata,
		output req_ready, rsp_valid, rsp_rdata
	);

endinterface

// File: logic/reg_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file import cpu_pkg::*; (
	input  logic     clk_g,
	input  logic     rst_i,
	input  reg_idx_t ra_i,
	input  reg_idx_t rb_i,
	output word_t    a_o,
	output word_t    b_o,
	input  logic     we_i,
	input  reg_idx_t wa_i,
	input  word_t    wd_i
);

	word_t regs [`CPU_NREGS];

	// r0 reads zero
	assign a_o = (ra_i == '0) ? '0 : regs[ra_i];
	assign b_o = (rb_i == '0) ? '0 : regs[rb_i];

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && wa_i != '0) begin
			regs[wa_i] <= wd_i;
		end
	end

endmodule

// File: tb/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb import cpu_pkg::*; ();

	localparam int MEM_WORDS = 256;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_WAIT = 4;
	localparam int MAX_DELAY = 3;
	localparam int SEED = 32'h5fc8;
	localparam int STEP_LIMIT = 2000;
	localparam int SETTLE = 20;

	logic  clk_g;
	logic  rst_i;
	logic  mem_req_valid_o;
	logic  mem_req_ready_i;
	logic  mem_req_we_o;
	addr_t mem_req_addr_o;
	word_t mem_req_wdata_o;
	logic  mem_rsp_valid_i;
	word_t mem_rsp_rdata_i;
	logic  halted_o;

	insn_t img [MEM_WORDS];
	int    n_words;
	addr_t exp_addr [$];
	word_t exp_data [$];
	logic  ref_halted;
	int    n_stores;
	int    errors;
	int    tests_run;
	int    tests_failed;
	int    cycle_cnt = 0;
	int    cycle_limit = 1000;
	string cur_test = "none";
	logic  checking;
	logic  first_req;
	logic  stalled;
	logic  held_we;
	addr_t held_addr;
	word_t held_wdata;

	cpu_core_top dut0 (
		.clk_g, .rst_i,
		.mem_req_valid_o, .mem_req_ready_i, .mem_req_we_o,
		.mem_req_addr_o, .mem_req_wdata_o,
		.mem_rsp_valid_i, .mem_rsp_rdata_i,
		.halted_o
	);

	tb_memory #(
		.DEPTH(MEM_WORDS), .SEED(SEED), .MAX_WAIT(MAX_WAIT), .MAX_DELAY(MAX_DELAY)
	) mem0 (
		.clk_g, .rst_i,
		.req_valid_i(mem_req_valid_o), .req_ready_o(mem_req_ready_i),
		.req_we_i(mem_req_we_o), .req_addr_i(mem_req_addr_o),
		.req_wdata_i(mem_req_wdata_o),
		.rsp_valid_o(mem_rsp_valid_i), .rsp_rdata_o(mem_rsp_rdata_i)
	);

	initial begin
		clk_g = 1'b0;
		forever #4 clk_g = ~clk_g;
	end

	task automatic report_error(string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_halt(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic insn_t encode(opcode_t op, int rt, int ra, int rb, int imm);
		return {op, reg_idx_t'(rt), reg_idx_t'(ra), reg_idx_t'(rb), imm[15:0]};
	endfunction

	task automatic emit(insn_t w);
		img[n_words] = w;
		n_words++;
	endtask

	task automatic clear_image();
		addr_t a;
		for (int i = 0; i < MEM_WORDS; i++) begin
			a = addr_t'(i * 4);
			img[i] = a ^ (a << 13) ^ 32'hc3c3_0000;
		end
		n_words = 0;
	endtask

	// ISA model that fills the expected store list and returns the instruction count
	function automatic int ref_run();
		word_t m [MEM_WORDS];
		word_t r [16];
		addr_t pc;
		addr_t ea;
		insn_t w;
		word_t a;
		word_t b;
		word_t t;
		word_t simm;
		int    rd;
		int    n;
		for (int i = 0; i < MEM_WORDS; i++)
			m[i] = img[i];
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		exp_addr.delete();
		exp_data.delete();
		ref_halted = 1'b0;
		pc = '0;
		n = 0;
		while (!ref_halted && n < STEP_LIMIT) begin
			w = m[(pc >> 2) % MEM_WORDS];
			rd = w[27:24];
			a = r[w[23:20]];
			b = r[w[19:16]];
			t = r[rd];
			simm = {{16{w[15]}}, w[15:0]};
			ea = a + simm;
			pc = pc + 4;
			n++;
			case (w[31:28])
			OP_ADD:   r[rd] = a + b;
			OP_AND:   r[rd] = a & b;
			OP_OR:    r[rd] = a | b;
			OP_EOR:   r[rd] = a ^ b;
			OP_CMP:   r[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_SHL:   r[rd] = a << b[4:0];
			OP_SHR:   r[rd] = a >> b[4:0];
			OP_ASR:   r[rd] = $signed(a) >>> b[4:0];
			OP_ADDI:  r[rd] = a + simm;
			OP_LOAD:  r[rd] = m[(ea >> 2) % MEM_WORDS];
			OP_STORE: begin
				m[(ea >> 2) % MEM_WORDS] = t;
				exp_addr.push_back(ea);
				exp_data.push_back(t);
			end
			OP_BEQ:   if (a == t) pc = pc + (simm << 2);
			OP_BNE:   if (a != t) pc = pc + (simm << 2);
			OP_HALT:  ref_halted = 1'b1;
			default: ;
			endcase
			r[0] = '0;
		end
		return n;
	endfunction

	task automatic build_alu();
		opcode_t ops [5];
		int      src [4];
		int      k;
		ops = '{OP_ADD, OP_AND, OP_OR, OP_EOR, OP_CMP};
		src = '{1, 2, 3, 1};
		k = 0;
		clear_image();
		emit(encode(OP_ADDI, 1, 0, 0, 1234));
		emit(encode(OP_ADDI, 2, 0, 0, -77));
		emit(encode(OP_ADDI, 3, 2, 0, -30000));
		// unused opcode does nothing
		emit(insn_t'(32'hd123_4567));
		for (int i = 0; i < 5; i++)
			for (int j = 0; j < 3; j++) begin
				emit(encode(ops[i], 4, src[j], src[j + 1], 0));
				emit(encode(OP_STORE, 4, 0, 0, 'h200 + 4 * k));
				k++;
			end
		emit(encode(OP_STORE, 3, 0, 0, 'h200 + 4 * k));
		emit(encode(OP_HALT, 0, 0, 0, 0));
	endtask

	task automatic build_shift();
		opcode_t ops [3];
		int      amt [5];
		int      k;
		ops = '{OP_SHL, OP_SHR, OP_ASR};
		amt = '{0, 1, 13, 31, 36};
		k = 0;
		clear_image();
		emit(encode(OP_ADDI, 1, 0, 0, -1000));
		emit(encode(OP_ADDI, 2, 0, 0, 'h5a5a));
		for (int i = 0; i < 5; i++)
			emit(encode(OP_ADDI, 3 + i, 0, 0, amt[i]));
		for (int s = 1; s <= 2; s++)
			for (int i = 3; i <= 7; i++)
				for (int j = 0; j < 3; j++) begin
					emit(encode(ops[j], 8, s, i, 0));
					emit(encode(OP_STORE, 8, 0, 0, 'h200 + 4 * k));
					k++;
				end
		emit(encode(OP_HALT, 0, 0, 0, 0));
	endtask

	task automatic build_mem();
		clear_image();
		emit(encode(OP_ADDI, 1, 0, 0, 'h300));
		emit(encode(OP_ADDI, 2, 0, 0, -5));
		emit(encode(OP_ADDI, 3, 0, 0, 'h1234));
		emit(encode(OP_STORE, 2, 1, 0, 0));
		emit(encode(OP_STORE, 3, 1, 0, 4));
		emit(encode(OP_LOAD, 4, 1, 0, 0));
		emit(encode(OP_LOAD, 5, 1, 0, 4));
		emit(encode(OP_STORE, 4, 1, 0, 'h10));
		emit(encode(OP_STORE, 5, 1, 0, 'h14));
		// r0 as destination of a load and an addi
		emit(encode(OP_LOAD, 0, 1, 0, 4));
		emit(encode(OP_ADDI, 0, 3, 0, 99));
		emit(encode(OP_STORE, 0, 1, 0, 'h18));
		emit(encode(OP_LOAD, 6, 1, 0, -'h40));
		emit(encode(OP_STORE, 6, 1, 0, 'h1c));
		emit(encode(OP_HALT, 0, 0, 0, 0));
	endtask

	task automatic build_branch();
		clear_image();
		emit(encode(OP_ADDI, 1, 0, 0, 3));
		emit(encode(OP_ADDI, 2, 0, 0, 0));
		emit(encode(OP_ADDI, 4, 0, 0, 'h200));
		// loop body runs three times
		emit(encode(OP_ADD, 2, 2, 1, 0));
		emit(encode(OP_STORE, 2, 4, 0, 0));
		emit(encode(OP_ADDI, 4, 4, 0, 4));
		emit(encode(OP_ADDI, 1, 1, 0, -1));
		emit(encode(OP_BNE, 0, 1, 0, -5));
		emit(encode(OP_BEQ, 0, 1, 0, 1));
		emit(encode(OP_STORE, 2, 0, 0, 'h240));
		emit(encode(OP_BEQ, 0, 2, 0, 1));
		emit(encode(OP_STORE, 2, 0, 0, 'h244));
		emit(encode(OP_BNE, 2, 2, 0, 1));
		emit(encode(OP_STORE, 1, 0, 0, 'h248));
		emit(encode(OP_BNE, 0, 2, 0, 2));
		emit(encode(OP_STORE, 2, 0, 0, 'h24c));
		emit(encode(OP_HALT, 0, 0, 0, 0));
		emit(encode(OP_STORE, 4, 0, 0, 'h250));
		emit(encode(OP_BEQ, 0, 0, 0, 1));
		emit(encode(OP_STORE, 2, 0, 0, 'h254));
		emit(encode(OP_HALT, 0, 0, 0, 0));
	endtask

	task automatic run_test(string name);
		int count;
		int errs0;
		count = ref_run();
		errs0 = errors;
		if (!ref_halted)
			report_error({"reference run of ", name, " did not reach HALT"});
		@(negedge clk_g);
		cur_test = name;
		cycle_cnt = 0;
		cycle_limit = count * (2 * (MAX_WAIT + MAX_DELAY + 2) + 4) + RESET_CYCLES + SETTLE;
		checking = 1'b0;
		rst_i = 1'b1;
		for (int i = 0; i < MEM_WORDS; i++)
			mem0.mem[i] = img[i];
		repeat (RESET_CYCLES) @(negedge clk_g);
		rst_i = 1'b0;
		n_stores = 0;
		first_req = 1'b1;
		stalled = 1'b0;
		checking = 1'b1;
		@(negedge clk_g);
		check_halt("mem_req_valid_o", mem_req_valid_o, 1'b0);
		check_halt("halted_o", halted_o, 1'b0);
		while (halted_o !== 1'b1)
			@(negedge clk_g);
		if (n_stores != exp_addr.size())
			report_error($sformatf("%0d stores before halt, %0d expected",
				n_stores, exp_addr.size()));
		repeat (SETTLE) @(negedge clk_g);
		check_halt("halted_o", halted_o, 1'b1);
		checking = 1'b0;
		tests_run++;
		if (errors != errs0)
			tests_failed++;
		$display("test %s: %s, %0d stores, %0d instructions", name,
			(errors == errs0) ? "passed" : "failed", n_stores, count);
	endtask

	// request stability, store order and silence after halt
	always @(posedge clk_g) begin
		if (checking) begin
			if (halted_o)
				check_halt("mem_req_valid_o", mem_req_valid_o, 1'b0);
			if (stalled) begin
				if (!mem_req_valid_o) begin
					check_halt("mem_req_valid_o", mem_req_valid_o, 1'b1);
				end else begin
					check_addr("mem_req_addr_o", mem_req_addr_o, held_addr);
					check_data("mem_req_wdata_o", mem_req_wdata_o, held_wdata);
					check_halt("mem_req_we_o", mem_req_we_o, held_we);
				end
			end
			stalled = mem_req_valid_o && !mem_req_ready_i;
			held_we = mem_req_we_o;
			held_addr = mem_req_addr_o;
			held_wdata = mem_req_wdata_o;
			if (mem_req_valid_o && mem_req_ready_i) begin
				if (first_req) begin
					first_req = 1'b0;
					check_halt("mem_req_we_o", mem_req_we_o, 1'b0);
					check_addr("mem_req_addr_o", mem_req_addr_o, '0);
				end
				if (mem_req_we_o) begin
					if (n_stores < exp_addr.size()) begin
						check_addr("mem_req_addr_o", mem_req_addr_o, exp_addr[n_stores]);
						check_data("mem_req_wdata_o", mem_req_wdata_o, exp_data[n_stores]);
					end else begin
						report_error("store beyond the expected sequence");
					end
					n_stores++;
				end
			end
		end
	end

	initial begin
		do begin
			@(posedge clk_g);
			cycle_cnt++;
		end while (cycle_cnt < cycle_limit);
		$display("Error at %0t: test %s still running after %0d cycles",
			$time, cur_test, cycle_limit);
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors + 1);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		rst_i = 1'b1;
		checking = 1'b0;
		first_req = 1'b0;
		stalled = 1'b0;
		n_stores = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		build_alu();
		run_test("alu");
		build_shift();
		run_test("shift");
		build_mem();
		run_test("memory");
		build_branch();
		run_test("branch");
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: tb/tb_memory.sv
`timescale 1ns/1ps

module tb_memory import cpu_pkg::*; #(
	parameter int DEPTH = 256,
	parameter int SEED = 1,
	parameter int MAX_WAIT = 4,
	parameter int MAX_DELAY = 3
) (
	input  logic  clk_g,
	input  logic  rst_i,
	input  logic  req_valid_i,
	output logic  req_ready_o,
	input  logic  req_we_i,
	input  addr_t req_addr_i,
	input  word_t req_wdata_i,
	output logic  rsp_valid_o,
	output word_t rsp_rdata_o
);

	word_t  mem [DEPTH];
	integer seed = SEED;
	integer rnd;
	int     wait_cnt = 0;
	int     delay_left = 0;
	logic   busy = 1'b0;
	logic   ready_q = 1'b0;
	logic   rsp_q = 1'b0;
	word_t  rdata_q = '0;

	assign req_ready_o = ready_q;
	assign rsp_valid_o = rsp_q;
	assign rsp_rdata_o = rdata_q;

	// outputs change on the falling edge only
	always @(negedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			busy = 1'b0;
			ready_q = 1'b0;
			rsp_q = 1'b0;
			wait_cnt = 0;
		end else begin
			rsp_q = 1'b0;
			if (busy) begin
				ready_q = 1'b0;
				if (delay_left == 0) begin
					rsp_q = 1'b1;
					busy = 1'b0;
				end else begin
					delay_left--;
				end
			end else if (req_valid_i) begin
				rnd = $random(seed);
				// ready forced after MAX_WAIT stalled cycles
				ready_q = (wait_cnt >= MAX_WAIT) || rnd[0];
				if (ready_q) begin
					// transfer happens at the next rising edge
					busy = 1'b1;
					wait_cnt = 0;
					delay_left = {$random(seed)} % (MAX_DELAY + 1);
					if (req_we_i) begin
						mem[(req_addr_i >> 2) % DEPTH] = req_wdata_i;
						rdata_q = '0;
					end else begin
						rdata_q = mem[(req_addr_i >> 2) % DEPTH];
					end
				end else begin
					wait_cnt++;
				end
			end else begin
				ready_q = 1'b0;
				wait_cnt = 0;
			end
		end
	end

endmodule
